// ==== noc_io_link_input.txt ====
# F addr data op src_id | R data pkt_type dst_id | S ch stall | G gaps | W sync and check
# Forward only, then reverse only, then mixed
F 1000 deadbeef 1 3
F 1004 01234567 2 3
F 2008 89abcdef 0 5
W x
R cafef00d 1 2
R 00000001 3 7
R ffffffff 0 f
W x
F 3000 11111111 3 1
R 22222222 2 4
F 3004 33333333 1 1
R 44444444 1 4
W x
# Reverse consumer stalls while forward flows, then release
S 1 1
R 50000001 1 9
R 50000002 1 9
R 50000003 1 9
R 50000004 1 9
R 50000005 1 9
R 50000006 1 9
F 4000 60000001 2 6
F 4004 60000002 2 6
F 4008 60000003 2 6
F 400c 60000004 2 6
F 4010 60000005 2 6
W x
S 1 0
W x
# Random yumi gaps, then a burst held on both channels
G 1
F 5000 70000001 1 2
R 80000001 2 8
F 5004 70000002 3 2
R 80000002 0 8
F 5008 70000003 0 2
W x
S 0 1
S 1 1
F 6000 90000001 1 a
F 6004 90000002 1 a
F 6008 90000003 1 a
F 600c 90000004 1 a
F 6010 90000005 1 a
R a0000001 3 b
R a0000002 3 b
R a0000003 3 b
R a0000004 3 b
R a0000005 3 b
W x
S 0 0
S 1 0
W x

// ==== vlog.f ====
noc_link_pkg.sv
noc_tunnel_mux.sv
noc_link_fifo.sv
noc_tunnel_demux.sv
noc_io_link.sv
noc_io_link_checker.sv
tb_clock_gen.sv
noc_io_link_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= noc_io_link_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== noc_io_link_tb.sv ====
`timescale 1ns/1ns

module noc_io_link_tb;

  localparam credits_lp = noc_link_pkg::credits_gp;
  localparam timeout_lp = 2000;

  logic clk_i;
  logic reset_i = 1'b1;
  logic fwd_v_i = 1'b0;
  logic rev_v_i = 1'b0;
  logic fwd_yumi_i = 1'b0;
  logic rev_yumi_i = 1'b0;
  noc_link_pkg::fwd_pkt_s fwd_data_i = '0;
  noc_link_pkg::rev_pkt_s rev_data_i = '0;
  logic fwd_ready_o, rev_ready_o, fwd_v_o, rev_v_o;
  noc_link_pkg::fwd_pkt_s fwd_data_o;
  noc_link_pkg::rev_pkt_s rev_data_o;

  noc_link_pkg::fwd_pkt_s fwd_send_q[$], fwd_exp_q[$];
  noc_link_pkg::rev_pkt_s rev_send_q[$], rev_exp_q[$];
  logic [1:0] stall = 2'b00;  // Per channel yumi hold
  logic gaps = 1'b0;
  integer seed = 56;
  int mismatches = 0;
  int timeouts = 0;
  int others = 0;

  tb_clock_gen clk_gen (.clk_o(clk_i));

  noc_io_link
 #(.credits_p      (credits_lp)
  ,.lg_fifo_depth_p(noc_link_pkg::lg_fifo_depth_gp)
  ) noc_io_link_inst
  (.clk_i(clk_i), .reset_i(reset_i)
  ,.fwd_v_i(fwd_v_i), .fwd_data_i(fwd_data_i), .fwd_ready_o(fwd_ready_o)
  ,.rev_v_i(rev_v_i), .rev_data_i(rev_data_i), .rev_ready_o(rev_ready_o)
  ,.fwd_v_o(fwd_v_o), .fwd_data_o(fwd_data_o), .fwd_yumi_i(fwd_yumi_i)
  ,.rev_v_o(rev_v_o), .rev_data_o(rev_data_o), .rev_yumi_i(rev_yumi_i)
  );

  task automatic compare_fwd(input string name, input noc_link_pkg::fwd_pkt_s got,
                             input noc_link_pkg::fwd_pkt_s exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_rev(input string name, input noc_link_pkg::rev_pkt_s got,
                             input noc_link_pkg::rev_pkt_s exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      mismatches++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("errors: mismatches %0d, timeouts %0d, other %0d", mismatches, timeouts, others);
    if (mismatches + timeouts + others == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  // Accepted by the DUT but not yet drained
  function automatic int outstanding(input int ch);
    if (ch == 0)
      return fwd_exp_q.size() - fwd_send_q.size();
    return rev_exp_q.size() - rev_send_q.size();
  endfunction

  function automatic bit chan_done(input int ch);
    if (stall[ch[0]])
      return outstanding(ch) == credits_lp;
    if (ch == 0)
      return fwd_send_q.size() == 0 && fwd_exp_q.size() == 0;
    return rev_send_q.size() == 0 && rev_exp_q.size() == 0;
  endfunction

  // Acceptance is seen on the rising edge
  always @(posedge clk_i)
  begin
    if (!reset_i && fwd_v_i && fwd_ready_o)
      void'(fwd_send_q.pop_front());
    if (!reset_i && rev_v_i && rev_ready_o)
      void'(rev_send_q.pop_front());
  end

  always @(negedge clk_i)
  begin
    fwd_v_i = !reset_i && fwd_send_q.size() > 0;
    if (fwd_v_i)
      fwd_data_i = fwd_send_q[0];
    rev_v_i = !reset_i && rev_send_q.size() > 0;
    if (rev_v_i)
      rev_data_i = rev_send_q[0];

    fwd_yumi_i = 1'b0;
    if (!reset_i && fwd_v_o && !stall[0] && (!gaps || ($random(seed) & 1) == 1))
    begin
      fwd_yumi_i = 1'b1;
      if (fwd_exp_q.size() == 0)
      begin
        others++;
        $display("Forward output carried a packet that was never sent");
      end
      else
        compare_fwd("fwd_data_o", fwd_data_o, fwd_exp_q.pop_front());
    end

    rev_yumi_i = 1'b0;
    if (!reset_i && rev_v_o && !stall[1] && (!gaps || ($random(seed) & 1) == 1))
    begin
      rev_yumi_i = 1'b1;
      if (rev_exp_q.size() == 0)
      begin
        others++;
        $display("Reverse output carried a packet that was never sent");
      end
      else
        compare_rev("rev_data_o", rev_data_o, rev_exp_q.pop_front());
    end
  end

  task automatic sync_segment();
    int cycles;
    cycles = 0;
    while (!(chan_done(0) && chan_done(1)))
    begin
      @(negedge clk_i);
      cycles++;
      if (cycles > timeout_lp)
      begin
        timeouts++;
        $display("Timed out waiting for a traffic segment to drain");
        return;
      end
    end
    if (stall != 2'b00)
    begin
      repeat (20) @(negedge clk_i);  // Give a lost credit time to show
      if (stall[0])
      begin
        compare_count("fwd outstanding", outstanding(0), credits_lp);
        compare_bit("fwd_ready_o", fwd_ready_o, 1'b0);
      end
      if (stall[1])
      begin
        compare_count("rev outstanding", outstanding(1), credits_lp);
        compare_bit("rev_ready_o", rev_ready_o, 1'b0);
      end
    end
    cycles = 0;
    while (!((stall[0] | fwd_ready_o) & (stall[1] | rev_ready_o)))
    begin
      @(negedge clk_i);
      cycles++;
      if (cycles > timeout_lp)
      begin
        timeouts++;
        $display("Timed out waiting for ready to return after the segment");
        return;
      end
    end
  endtask

  initial
  begin
    int fd;
    string line;
    logic [31:0] f1, f2, f3, f4;
    noc_link_pkg::fwd_pkt_s fp;
    noc_link_pkg::rev_pkt_s rp;

    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    fd = $fopen("noc_io_link_input.txt", "r");
    if (fd == 0)
    begin
      others++;
      $display("Could not open the stimulus file noc_io_link_input.txt");
    end
    else
    begin
      while (timeouts == 0 && $fgets(line, fd) != 0)
      begin
        if (line.len() > 2)
        begin
          f1 = '0;
          f2 = '0;
          f3 = '0;
          f4 = '0;
          void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", f1, f2, f3, f4));
          case (line.getc(0))
            "F":
            begin
              fp = '{addr: f1[15:0], data: f2, op: f3[1:0], src_id: f4[3:0]};
              fwd_send_q.push_back(fp);
              fwd_exp_q.push_back(fp);
            end
            "R":
            begin
              rp = '{data: f1, pkt_type: f2[1:0], dst_id: f3[3:0], pad: 16'h0};
              rev_send_q.push_back(rp);
              rev_exp_q.push_back(rp);
            end
            "S": stall[f1[0]] = f2[0];
            "G": gaps = f1[0];
            "W": sync_segment();
            default: ;  // Comment lines
          endcase
        end
      end
      $fclose(fd);
    end
    finish_run();
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
 #(parameter half_period_p = 2  // 4 ns period
  )
  (output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #half_period_p clk_o = ~clk_o;
  end

endmodule

// ==== noc_io_link_checker.sv ====
`timescale 1ns/1ns

module noc_io_link_checker
 #(parameter credits_p = noc_link_pkg::credits_gp
  )
  (input clk_i
  ,input reset_i
  ,input fwd_v_i
  ,input fwd_ready_o
  ,input fwd_v_o
  ,input fwd_yumi_i
  ,input rev_v_i
  ,input rev_ready_o
  ,input rev_v_o
  ,input rev_yumi_i
  );

  int fwd_out_r, rev_out_r;  // Accepted but not yet drained

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      fwd_out_r <= 0;
      rev_out_r <= 0;
    end
    else
    begin
      fwd_out_r <= fwd_out_r + int'(fwd_v_i & fwd_ready_o) - int'(fwd_yumi_i);
      rev_out_r <= rev_out_r + int'(rev_v_i & rev_ready_o) - int'(rev_yumi_i);
    end
  end

  // Queues are cleared by the first reset edge
  no_v_in_reset: assert property (@(posedge clk_i) reset_i && $past(reset_i) |-> !fwd_v_o && !rev_v_o)
    else $error("output valid high during reset");

  fwd_yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i) fwd_yumi_i |-> fwd_v_o)
    else $error("fwd_yumi_i without fwd_v_o");

  rev_yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i) rev_yumi_i |-> rev_v_o)
    else $error("rev_yumi_i without rev_v_o");

  fwd_out_bound: assert property (@(posedge clk_i) disable iff (reset_i) fwd_out_r <= credits_p)
    else $error("fwd outstanding above credits");

  rev_out_bound: assert property (@(posedge clk_i) disable iff (reset_i) rev_out_r <= credits_p)
    else $error("rev outstanding above credits");

endmodule

bind noc_io_link noc_io_link_checker
 #(.credits_p(credits_p)
  ) checker_inst
  (.clk_i      (clk_i)
  ,.reset_i    (reset_i)
  ,.fwd_v_i    (fwd_v_i)
  ,.fwd_ready_o(fwd_ready_o)
  ,.fwd_v_o    (fwd_v_o)
  ,.fwd_yumi_i (fwd_yumi_i)
  ,.rev_v_i    (rev_v_i)
  ,.rev_ready_o(rev_ready_o)
  ,.rev_v_o    (rev_v_o)
  ,.rev_yumi_i (rev_yumi_i)
  );

// ==== noc_io_link.sv ====
`timescale 1ns/1ns

module noc_io_link
 #(parameter credits_p       = noc_link_pkg::credits_gp
  ,parameter lg_fifo_depth_p = noc_link_pkg::lg_fifo_depth_gp
  )
  (input                             clk_i
  ,input                             reset_i

  ,input                             fwd_v_i
  ,input  noc_link_pkg::fwd_pkt_s    fwd_data_i
  ,output logic                      fwd_ready_o

  ,input                             rev_v_i
  ,input  noc_link_pkg::rev_pkt_s    rev_data_i
  ,output logic                      rev_ready_o

  ,output logic                      fwd_v_o
  ,output noc_link_pkg::fwd_pkt_s    fwd_data_o
  ,input                             fwd_yumi_i

  ,output logic                      rev_v_o
  ,output noc_link_pkg::rev_pkt_s    rev_data_o
  ,input                             rev_yumi_i
  );

  logic                     link_v, link_ready;
  noc_link_pkg::link_word_s link_word;
  logic                     head_v, head_yumi;
  noc_link_pkg::link_word_s head_word;
  logic [1:0]               credit_return;

  noc_tunnel_mux
 #(.credits_p      (credits_p)
  ) mux
  (.clk_i          (clk_i)
  ,.reset_i        (reset_i)
  ,.fwd_v_i        (fwd_v_i)
  ,.fwd_data_i     (fwd_data_i)
  ,.fwd_ready_o    (fwd_ready_o)
  ,.rev_v_i        (rev_v_i)
  ,.rev_data_i     (rev_data_i)
  ,.rev_ready_o    (rev_ready_o)
  ,.credit_return_i(credit_return)
  ,.link_v_o       (link_v)
  ,.link_word_o    (link_word)
  ,.link_ready_i   (link_ready)
  );

  noc_link_fifo
 #(.lg_depth_p(lg_fifo_depth_p)
  ) link_fifo
  (.clk_i     (clk_i)
  ,.reset_i   (reset_i)
  ,.v_i       (link_v)
  ,.data_i    (link_word)
  ,.ready_o   (link_ready)
  ,.v_o       (head_v)
  ,.data_o    (head_word)
  ,.yumi_i    (head_yumi)
  );

  noc_tunnel_demux
 #(.credits_p      (credits_p)
  ) demux
  (.clk_i          (clk_i)
  ,.reset_i        (reset_i)
  ,.head_v_i       (head_v)
  ,.head_word_i    (head_word)
  ,.head_yumi_o    (head_yumi)
  ,.fwd_v_o        (fwd_v_o)
  ,.fwd_data_o     (fwd_data_o)
  ,.fwd_yumi_i     (fwd_yumi_i)
  ,.rev_v_o        (rev_v_o)
  ,.rev_data_o     (rev_data_o)
  ,.rev_yumi_i     (rev_yumi_i)
  ,.credit_return_o(credit_return)
  );

endmodule

// ==== noc_tunnel_demux.sv ====
`timescale 1ns/1ns

module noc_tunnel_demux
 #(parameter credits_p = noc_link_pkg::credits_gp
  )
  (input                             clk_i
  ,input                             reset_i

  ,input                             head_v_i
  ,input  noc_link_pkg::link_word_s  head_word_i
  ,output logic                      head_yumi_o

  ,output logic                      fwd_v_o
  ,output noc_link_pkg::fwd_pkt_s    fwd_data_o
  ,input                             fwd_yumi_i

  ,output logic                      rev_v_o
  ,output noc_link_pkg::rev_pkt_s    rev_data_o
  ,input                             rev_yumi_i

  ,output logic [1:0]                credit_return_o
  );

  localparam pkt_w_lp = $bits(noc_link_pkg::fwd_pkt_s);
  localparam ptr_w_lp = (credits_p > 1) ? $clog2(credits_p) : 1;
  localparam cnt_w_lp = $clog2(credits_p+1);

  logic [1:0][pkt_w_lp-1:0] push_data, head_data;
  logic [1:0] push, v_lo, yumi_li;

  function automatic logic [ptr_w_lp-1:0] ptr_inc(input logic [ptr_w_lp-1:0] ptr);
    if (ptr == ptr_w_lp'(credits_p-1))
      return '0;
    return ptr + ptr_w_lp'(1);
  endfunction

  // Credits guarantee room, so the head never waits
  assign head_yumi_o = head_v_i;

  // Each queue is filled through its own view of the payload
  assign push_data[noc_link_pkg::CH_FWD] = head_word_i.payload.fwd;
  assign push_data[noc_link_pkg::CH_REV] = head_word_i.payload.rev;

  assign yumi_li[noc_link_pkg::CH_FWD] = fwd_yumi_i;
  assign yumi_li[noc_link_pkg::CH_REV] = rev_yumi_i;

  for (genvar i = 0; i < 2; i++)
  begin: q
    logic [pkt_w_lp-1:0] mem_r [credits_p];
    logic [ptr_w_lp-1:0] wptr_r, rptr_r;
    logic [cnt_w_lp-1:0] count_r;

    assign push[i]      = head_v_i & (head_word_i.ch == noc_link_pkg::noc_ch_e'(i));
    assign v_lo[i]      = (count_r != '0);
    assign head_data[i] = mem_r[rptr_r];

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        wptr_r  <= '0;
        rptr_r  <= '0;
        count_r <= '0;
      end
      else
      begin
        if (push[i])
          wptr_r <= ptr_inc(wptr_r);
        if (yumi_li[i])
          rptr_r <= ptr_inc(rptr_r);
        if (push[i] & ~yumi_li[i])
          count_r <= count_r + cnt_w_lp'(1);
        else if (~push[i] & yumi_li[i])
          count_r <= count_r - cnt_w_lp'(1);
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (push[i])
        mem_r[wptr_r] <= push_data[i];
    end
  end

  assign fwd_v_o    = v_lo[noc_link_pkg::CH_FWD];
  assign fwd_data_o = noc_link_pkg::fwd_pkt_s'(head_data[noc_link_pkg::CH_FWD]);
  assign rev_v_o    = v_lo[noc_link_pkg::CH_REV];
  assign rev_data_o = noc_link_pkg::rev_pkt_s'(head_data[noc_link_pkg::CH_REV]);

  // One credit back per drained packet, a cycle after the yumi
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credit_return_o <= '0;
    else
      credit_return_o <= yumi_li;
  end

endmodule

// ==== noc_link_fifo.sv ====
`timescale 1ns/1ns

module noc_link_fifo
 #(parameter lg_depth_p = noc_link_pkg::lg_fifo_depth_gp
  )
  (input                             clk_i
  ,input                             reset_i

  ,input                             v_i
  ,input  noc_link_pkg::link_word_s  data_i
  ,output logic                      ready_o

  ,output logic                      v_o
  ,output noc_link_pkg::link_word_s  data_o
  ,input                             yumi_i
  );

  localparam depth_lp = 1 << lg_depth_p;

  noc_link_pkg::link_word_s mem_r [depth_lp];

  // Top bit tells a full buffer from an empty one
  logic [lg_depth_p:0] wptr_r, rptr_r;
  logic full, empty, enq, deq;

  assign empty = (wptr_r == rptr_r);
  assign full  = (wptr_r[lg_depth_p] != rptr_r[lg_depth_p])
               & (wptr_r[lg_depth_p-1:0] == rptr_r[lg_depth_p-1:0]);

  assign ready_o = ~full | yumi_i;  // A pop frees the slot in the same cycle
  assign v_o     = ~empty;
  assign data_o  = mem_r[rptr_r[lg_depth_p-1:0]];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
    end
    else
    begin
      if (enq)
        wptr_r <= wptr_r + (lg_depth_p+1)'(1);
      if (deq)
        rptr_r <= rptr_r + (lg_depth_p+1)'(1);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r[lg_depth_p-1:0]] <= data_i;
  end

endmodule

// ==== noc_tunnel_mux.sv ====
`timescale 1ns/1ns

module noc_tunnel_mux
 #(parameter credits_p = noc_link_pkg::credits_gp
  )
  (input                             clk_i
  ,input                             reset_i

  ,input                             fwd_v_i
  ,input  noc_link_pkg::fwd_pkt_s    fwd_data_i
  ,output logic                      fwd_ready_o

  ,input                             rev_v_i
  ,input  noc_link_pkg::rev_pkt_s    rev_data_i
  ,output logic                      rev_ready_o

  ,input  [1:0]                      credit_return_i

  ,output logic                      link_v_o
  ,output noc_link_pkg::link_word_s  link_word_o
  ,input                             link_ready_i
  );

  localparam cnt_w_lp = $clog2(credits_p+1);

  logic [cnt_w_lp-1:0] credit_r [2];
  logic [1:0] v_li, has_credit, req, gnt;
  logic prio_rev_r;  // Set when rev wins the next tie
  logic slot_free;
  noc_link_pkg::link_word_s link_word_n;

  // Output register is empty or being taken by the FIFO this cycle
  assign slot_free = ~link_v_o | link_ready_i;

  assign v_li[noc_link_pkg::CH_FWD] = fwd_v_i;
  assign v_li[noc_link_pkg::CH_REV] = rev_v_i;

  for (genvar i = 0; i < 2; i++)
  begin: credit
    assign has_credit[i] = (credit_r[i] != '0);

    // Grant spends one, a returned pulse gives one back
    always_ff @(posedge clk_i)
    begin
      if (reset_i)
        credit_r[i] <= cnt_w_lp'(credits_p);
      else if (gnt[i] & ~credit_return_i[i])
        credit_r[i] <= credit_r[i] - cnt_w_lp'(1);
      else if (~gnt[i] & credit_return_i[i])
        credit_r[i] <= credit_r[i] + cnt_w_lp'(1);
    end
  end

  assign req = v_li & has_credit & {2{slot_free}};

  // Round robin between the two channels
  assign gnt[noc_link_pkg::CH_FWD] = req[noc_link_pkg::CH_FWD]
                                   & (~req[noc_link_pkg::CH_REV] | ~prio_rev_r);
  assign gnt[noc_link_pkg::CH_REV] = req[noc_link_pkg::CH_REV]
                                   & (~req[noc_link_pkg::CH_FWD] | prio_rev_r);

  // Ready does not look at the channel's own valid
  assign fwd_ready_o = has_credit[noc_link_pkg::CH_FWD] & slot_free
                     & ~(req[noc_link_pkg::CH_REV] & prio_rev_r);
  assign rev_ready_o = has_credit[noc_link_pkg::CH_REV] & slot_free
                     & ~(req[noc_link_pkg::CH_FWD] & ~prio_rev_r);

  always_comb
  begin
    link_word_n = link_word_o;
    if (gnt[noc_link_pkg::CH_FWD])
    begin
      link_word_n.ch          = noc_link_pkg::CH_FWD;
      link_word_n.payload.fwd = fwd_data_i;
    end
    else if (gnt[noc_link_pkg::CH_REV])
    begin
      link_word_n.ch          = noc_link_pkg::CH_REV;
      link_word_n.payload.rev = rev_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      link_v_o   <= 1'b0;
      prio_rev_r <= 1'b0;
    end
    else
    begin
      link_v_o <= (|gnt) | (link_v_o & ~link_ready_i);
      if (|gnt)
        prio_rev_r <= gnt[noc_link_pkg::CH_FWD];  // Other channel goes first next time
    end
  end

  always_ff @(posedge clk_i)
  begin
    link_word_o <= link_word_n;
  end

endmodule

// ==== noc_link_pkg.sv ====
package noc_link_pkg;

  // Channel tag carried with every link word
  typedef enum logic [0:0]
  {
    CH_FWD = 1'b0  // Requests
   ,CH_REV = 1'b1  // Returns
  } noc_ch_e;

  typedef struct packed
  {
    logic [15:0] addr;
    logic [31:0] data;
    logic [1:0]  op;
    logic [3:0]  src_id;
  } fwd_pkt_s;

  typedef struct packed
  {
    logic [31:0] data;
    logic [1:0]  pkt_type;
    logic [3:0]  dst_id;
    logic [15:0] pad;     // Always zero, keeps both views 54 bits
  } rev_pkt_s;

  // One payload word, decoded by the channel tag
  typedef union packed
  {
    fwd_pkt_s fwd;
    rev_pkt_s rev;
  } link_payload_u;

  typedef struct packed
  {
    noc_ch_e       ch;
    link_payload_u payload;
  } link_word_s;

  // Remote credits per channel, also the demux queue depth
  parameter int credits_gp = 4;

  // Link FIFO holds 2**lg_fifo_depth_gp words
  parameter int lg_fifo_depth_gp = 2;

endpackage
